/* logic/cpuPkg.sv */
package cpuPkg;

    // ********************
    // Widths and sizes
    // ********************
    localparam int dataWidth    = 8;
    localparam int pcWidth      = 8;            // 256 instruction words
    localparam int memAddrWidth = 16;
    localparam int dataDepth    = 256;          // Bytes of data RAM
    localparam int ramAddrWidth = $clog2(dataDepth);
    localparam int vidAddrWidth = 12;           // Offset from vidBase

    // ********************
    // Address map
    // ********************
    localparam logic [memAddrWidth-1:0] ramLast    = 16'h0FFF;   // RAM aliases below this
    localparam logic [memAddrWidth-1:0] ioDirAddr  = 16'h1000;
    localparam logic [memAddrWidth-1:0] ioPortAddr = 16'h1001;
    localparam logic [memAddrWidth-1:0] ioPinsAddr = 16'h1002;
    localparam logic [memAddrWidth-1:0] vidBase    = 16'h2000;
    localparam logic [memAddrWidth-1:0] vidLast    = 16'h2960;

    // ********************
    // Opcodes
    // ********************
    localparam logic [3:0] opLdi  = 4'h0;
    localparam logic [3:0] opAdd  = 4'h1;
    localparam logic [3:0] opSub  = 4'h2;
    localparam logic [3:0] opAnd  = 4'h3;
    localparam logic [3:0] opOr   = 4'h4;
    localparam logic [3:0] opXor  = 4'h5;
    localparam logic [3:0] opAdc  = 4'h6;
    localparam logic [3:0] opLd   = 4'h7;
    localparam logic [3:0] opSt   = 4'h8;
    localparam logic [3:0] opIncp = 4'h9;
    localparam logic [3:0] opBz   = 4'hA;
    localparam logic [3:0] opJmp  = 4'hB;
    localparam logic [3:0] opHalt = 4'hC;       // Codes D to F fall through as no-ops

    // Destination and 8-bit immediate
    typedef struct packed {
        logic [3:0]           rd;
        logic [dataWidth-1:0] imm;
        logic [3:0]           op;
    } immFormat;

    // Three register fields
    typedef struct packed {
        logic [3:0] rd;
        logic [3:0] rs;
        logic [3:0] rt;
        logic [3:0] op;
    } regFormat;

    // Same 16-bit word, two decodings
    typedef union packed {
        immFormat immForm;
        regFormat regForm;
    } instrWord;

    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
    } flagsWord;

endpackage

/* logic/fetchStage.sv */
`timescale 1ns/10ps

module fetchStage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       run,
    input  logic                       progWe,
    input  logic [cpuPkg::pcWidth-1:0] progAddr,
    input  logic [15:0]                progData,
    input  logic                       wbDone,
    input  logic                       halt,
    input  logic                       branchTaken,
    input  logic [cpuPkg::pcWidth-1:0] branchTarget,
    output cpuPkg::instrWord           instr,
    output logic                       fetchValid,
    output logic                       halted
);
    import cpuPkg::*;

    logic [15:0]        rom [2**pcWidth];
    logic [pcWidth-1:0] pc;                     // Next address to fetch
    logic [pcWidth-1:0] fetchAddr;
    logic               busy;                   // One instruction in flight
    logic               issue;

    // Program load port, used while run is low
    always_ff @(posedge clk) begin
        if (progWe)
            rom[progAddr] <= progData;
    end

    // Branch outcome from execute is still held at retirement
    assign fetchAddr = (wbDone && branchTaken) ? branchTarget : pc;

    // Issue when idle, or on the retirement of a non-halt instruction
    assign issue = run && !halted && (!busy || (wbDone && !halt));

    always_ff @(posedge clk) begin
        if (issue)
            instr <= rom[fetchAddr];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= '0;
            busy       <= 1'b0;
            fetchValid <= 1'b0;
            halted     <= 1'b0;
        end else begin
            fetchValid <= issue;
            if (issue) begin
                pc   <= fetchAddr + 1'b1;
                busy <= 1'b1;
            end else if (wbDone) begin
                pc   <= fetchAddr;              // Resume here once run returns
                busy <= 1'b0;
            end
            halted <= halted | (wbDone & halt); // Sticky until reset
        end
    end

endmodule

/* logic/regFile.sv */
`timescale 1ns/10ps

module regFile (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [3:0]                   rs,
    input  logic [3:0]                   rt,
    input  logic [3:0]                   rd,
    input  logic [cpuPkg::dataWidth-1:0] wrData,
    input  logic                         we,
    input  logic                         incPair,
    output logic [cpuPkg::dataWidth-1:0] rsData,
    output logic [cpuPkg::dataWidth-1:0] rtData
);
    import cpuPkg::*;

    logic [dataWidth-1:0]   regs [16];
    logic [3:0]             evenSel;
    logic [3:0]             oddSel;
    logic [2*dataWidth-1:0] pairNext;

    // Combinational read ports
    assign rsData = regs[rs];
    assign rtData = regs[rt];

    // Pair is {odd, even}, low byte in the even register
    assign evenSel  = {rs[3:1], 1'b0};
    assign oddSel   = {rs[3:1], 1'b1};
    assign pairNext = {regs[oddSel], regs[evenSel]} + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 16; i++)
                regs[i] <= '0;
        end else if (we) begin
            regs[rd] <= wrData;                 // Write wins over increment
        end else if (incPair) begin
            regs[evenSel] <= pairNext[dataWidth-1:0];
            regs[oddSel]  <= pairNext[2*dataWidth-1:dataWidth];
        end
    end

endmodule

/* logic/decodeStage.sv */
`timescale 1ns/10ps

module decodeStage (
    input  logic                         clk,
    input  logic                         rst,
    input  cpuPkg::instrWord             instr,
    input  logic                         fetchValid,
    input  logic                         wbDone,
    input  logic [cpuPkg::dataWidth-1:0] wbData,
    output logic                         decValid,
    output logic [3:0]                   op,
    output logic [cpuPkg::dataWidth-1:0] imm,
    output logic [cpuPkg::dataWidth-1:0] opA,
    output logic [cpuPkg::dataWidth-1:0] opB,
    output logic [cpuPkg::dataWidth-1:0] storeData,
    output logic                         halt
);
    import cpuPkg::*;

    logic [3:0]           rdQ;                  // Destination, kept until retirement
    logic [3:0]           rsQ;                  // Pair base for opIncp
    logic [3:0]           rsSel;
    logic [3:0]           rtSel;
    logic [dataWidth-1:0] rsData;
    logic [dataWidth-1:0] rtData;
    logic                 writesReg;
    logic                 regWe;
    logic                 incPair;

    // ********************
    // Register file ports
    // ********************
    // Operands are read with fetchValid, the store source one cycle later
    assign rsSel = fetchValid ? instr.regForm.rs : rsQ;
    assign rtSel = fetchValid ? instr.regForm.rt : rdQ;
    assign storeData = rtData;                  // Valid during decValid

    always_comb begin
        case (op)
            opLdi, opAdd, opSub, opAnd, opOr, opXor, opAdc, opLd: writesReg = 1'b1;
            default:                                              writesReg = 1'b0;
        endcase
    end

    assign regWe   = wbDone && writesReg;
    assign incPair = wbDone && (op == opIncp);
    assign halt    = (op == opHalt);

    regFile registers (
        .clk     (clk),
        .rst     (rst),
        .rs      (rsSel),
        .rt      (rtSel),
        .rd      (rdQ),
        .wrData  (wbData),
        .we      (regWe),
        .incPair (incPair),
        .rsData  (rsData),
        .rtData  (rtData)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            decValid <= 1'b0;
            op       <= '0;
        end else begin
            decValid <= fetchValid;
            if (fetchValid)
                op <= instr.regForm.op;
        end
    end

    // Fields from both views of the word
    always_ff @(posedge clk) begin
        if (fetchValid) begin
            imm <= instr.immForm.imm;
            rdQ <= instr.immForm.rd;
            rsQ <= instr.regForm.rs;
            opA <= rsData;
            opB <= rtData;
        end
    end

endmodule

/* logic/executeStage.sv */
`timescale 1ns/10ps

module executeStage (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            decValid,
    input  logic [3:0]                      op,
    input  logic [cpuPkg::dataWidth-1:0]    imm,
    input  logic [cpuPkg::dataWidth-1:0]    opA,
    input  logic [cpuPkg::dataWidth-1:0]    opB,
    input  logic [cpuPkg::dataWidth-1:0]    storeData,
    output logic                            exValid,
    output logic [cpuPkg::dataWidth-1:0]    result,
    output logic [cpuPkg::memAddrWidth-1:0] memAddr,
    output logic                            memWe,
    output logic                            memRe,
    output logic [cpuPkg::dataWidth-1:0]    memData,
    output logic                            branchTaken,
    output logic [cpuPkg::pcWidth-1:0]      branchTarget
);
    import cpuPkg::*;

    flagsWord           flags;
    logic [dataWidth:0] aluSum;                 // Top bit is carry out
    logic               isAlu;

    // ********************
    // ALU
    // ********************
    always_comb begin
        aluSum = '0;
        isAlu  = 1'b1;
        case (op)
            opAdd:   aluSum = {1'b0, opA} + {1'b0, opB};
            opSub:   aluSum = {1'b0, opA} + {1'b0, ~opB} + 1'b1;  // Carry means no borrow
            opAdc:   aluSum = {1'b0, opA} + {1'b0, opB} + flags.carry;
            opAnd:   aluSum = {1'b0, opA & opB};
            opOr:    aluSum = {1'b0, opA | opB};
            opXor:   aluSum = {1'b0, opA ^ opB};
            default: isAlu  = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exValid     <= 1'b0;
            memWe       <= 1'b0;
            memRe       <= 1'b0;
            branchTaken <= 1'b0;
            flags       <= '0;
        end else begin
            exValid <= decValid;
            memWe   <= decValid && (op == opSt);  // Single-cycle strobes
            memRe   <= decValid && (op == opLd);
            if (decValid)
                branchTaken <= (op == opJmp) || ((op == opBz) && flags.zero);
            if (decValid && isAlu) begin
                flags.carry    <= aluSum[dataWidth];
                flags.zero     <= (aluSum[dataWidth-1:0] == '0);
                flags.negative <= aluSum[dataWidth-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (decValid) begin
            result       <= isAlu ? aluSum[dataWidth-1:0] : imm;  // opLdi takes imm
            memAddr      <= {opB, opA};
            memData      <= storeData;
            branchTarget <= imm[pcWidth-1:0];
        end
    end

endmodule

/* logic/memoryStage.sv */
`timescale 1ns/10ps

module memoryStage (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            exValid,
    input  logic [cpuPkg::dataWidth-1:0]    result,
    input  logic [cpuPkg::memAddrWidth-1:0] memAddr,
    input  logic                            memWe,
    input  logic                            memRe,
    input  logic [cpuPkg::dataWidth-1:0]    memData,
    input  logic [cpuPkg::dataWidth-1:0]    ioPins,
    output logic                            wbDone,
    output logic [cpuPkg::dataWidth-1:0]    wbData,
    output logic [cpuPkg::dataWidth-1:0]    ioDir,
    output logic [cpuPkg::dataWidth-1:0]    ioPort,
    output logic                            vidWe,
    output logic [cpuPkg::vidAddrWidth-1:0] vidAddr,
    output logic [cpuPkg::dataWidth-1:0]    vidData
);
    import cpuPkg::*;

    logic [dataWidth-1:0]    ram [dataDepth];
    logic [dataWidth-1:0]    loadData;
    logic [memAddrWidth-1:0] vidOffset;
    logic                    inRam;
    logic                    inVid;

    // ********************
    // Address map
    // ********************
    assign inRam     = (memAddr <= ramLast);
    assign inVid     = (memAddr >= vidBase) && (memAddr <= vidLast);
    assign vidOffset = memAddr - vidBase;

    // Video window goes straight out as a strobe
    assign vidWe   = memWe && inVid;
    assign vidAddr = vidOffset[vidAddrWidth-1:0];
    assign vidData = memData;

    always_ff @(posedge clk) begin
        if (memWe && inRam)
            ram[memAddr[ramAddrWidth-1:0]] <= memData;  // Low byte only, region aliases
    end

    always_comb begin
        loadData = '0;                          // Unmapped reads
        if (inRam)
            loadData = ram[memAddr[ramAddrWidth-1:0]];
        else if (memAddr == ioDirAddr)
            loadData = ioDir;
        else if (memAddr == ioPortAddr)
            loadData = ioPort;
        else if (memAddr == ioPinsAddr)
            loadData = ioPins;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wbDone <= 1'b0;
            ioDir  <= '0;
            ioPort <= '0;
        end else begin
            wbDone <= exValid;
            if (memWe && (memAddr == ioDirAddr))
                ioDir <= memData;
            if (memWe && (memAddr == ioPortAddr))
                ioPort <= memData;
        end
    end

    always_ff @(posedge clk) begin
        if (exValid)
            wbData <= memRe ? loadData : result;
    end

endmodule

/* logic/cpuTop.sv */
`timescale 1ns/10ps

module cpuTop (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            run,
    input  logic                            progWe,
    input  logic [cpuPkg::pcWidth-1:0]      progAddr,
    input  logic [15:0]                     progData,
    input  logic [cpuPkg::dataWidth-1:0]    ioPins,
    output logic                            halted,
    output logic [cpuPkg::dataWidth-1:0]    ioDir,
    output logic [cpuPkg::dataWidth-1:0]    ioPort,
    output logic                            vidWe,
    output logic [cpuPkg::vidAddrWidth-1:0] vidAddr,
    output logic [cpuPkg::dataWidth-1:0]    vidData
);
    import cpuPkg::*;

    // ********************
    // Stage links
    // ********************
    instrWord                instr;
    logic                    fetchValid;
    logic                    decValid;
    logic                    exValid;
    logic                    wbDone;
    logic                    halt;
    logic [3:0]              op;
    logic [dataWidth-1:0]    imm;
    logic [dataWidth-1:0]    opA;
    logic [dataWidth-1:0]    opB;
    logic [dataWidth-1:0]    storeData;
    logic [dataWidth-1:0]    result;
    logic [memAddrWidth-1:0] memAddr;
    logic                    memWe;
    logic                    memRe;
    logic [dataWidth-1:0]    memData;
    logic                    branchTaken;
    logic [pcWidth-1:0]      branchTarget;
    logic [dataWidth-1:0]    wbData;

    fetchStage fetch (
        .clk(clk), .rst(rst), .run(run), .progWe(progWe), .progAddr(progAddr),
        .progData(progData), .wbDone(wbDone), .halt(halt), .branchTaken(branchTaken),
        .branchTarget(branchTarget), .instr(instr), .fetchValid(fetchValid), .halted(halted)
    );

    decodeStage decode (
        .clk(clk), .rst(rst), .instr(instr), .fetchValid(fetchValid), .wbDone(wbDone),
        .wbData(wbData), .decValid(decValid), .op(op), .imm(imm), .opA(opA), .opB(opB),
        .storeData(storeData), .halt(halt)
    );

    executeStage execute (
        .clk(clk), .rst(rst), .decValid(decValid), .op(op), .imm(imm), .opA(opA),
        .opB(opB), .storeData(storeData), .exValid(exValid), .result(result),
        .memAddr(memAddr), .memWe(memWe), .memRe(memRe), .memData(memData),
        .branchTaken(branchTaken), .branchTarget(branchTarget)
    );

    memoryStage memory (
        .clk(clk), .rst(rst), .exValid(exValid), .result(result), .memAddr(memAddr),
        .memWe(memWe), .memRe(memRe), .memData(memData), .ioPins(ioPins),
        .wbDone(wbDone), .wbData(wbData), .ioDir(ioDir), .ioPort(ioPort),
        .vidWe(vidWe), .vidAddr(vidAddr), .vidData(vidData)
    );

endmodule

/* test/cpuTop_assertions.sv */
`timescale 1ns/10ps

module cpuTop_assertions (
    input logic                            clk,
    input logic                            rst,
    input logic                            vidWe,
    input logic [cpuPkg::vidAddrWidth-1:0] vidAddr,
    input logic                            halted,
    input logic                            fetchValid,
    input logic                            decValid,
    input logic                            exValid,
    input logic                            wbDone
);
    import cpuPkg::*;

    int failCount = 0;                          // Failed checks so far

    // Strobe offset stays inside the video window
    vidInWindow: assert property (@(posedge clk) disable iff (rst)
        vidWe |-> (16'(vidAddr) <= vidLast - vidBase))
        else begin
            failCount++;
            $error("vidWe with offset beyond the video window");
        end

    quietWhenHalted: assert property (@(posedge clk) disable iff (rst)
        halted |-> !vidWe)
        else begin
            failCount++;
            $error("vidWe while the core is halted");
        end

    // One instruction in flight means one token at a time
    singleToken: assert property (@(posedge clk) disable iff (rst)
        $onehot0({fetchValid, decValid, exValid, wbDone}))
        else begin
            failCount++;
            $error("More than one stage token high");
        end

endmodule

bind cpuTop cpuTop_assertions checks (.*);

/* test/cpuTb.sv */
`timescale 1ns/10ps

module cpuTb;
    import cpuPkg::*;

    localparam int numPrograms = 44;
    localparam int cycleLimit  = numPrograms * (256 * 4 + 300);  // Load and reset in margin

    logic                        clk = 1'b0;
    logic                        rst;
    logic                        run;
    logic                        progWe;
    logic [pcWidth-1:0]          progAddr;
    logic [15:0]                 progData;
    logic [dataWidth-1:0]        ioPins;
    logic                        halted;
    logic [dataWidth-1:0]        ioDir;
    logic [dataWidth-1:0]        ioPort;
    logic                        vidWe;
    logic [vidAddrWidth-1:0]     vidAddr;
    logic [dataWidth-1:0]        vidData;

    instrWord                    prog [2**pcWidth];
    int                          progLen;
    logic [15:0]                 lfsr = 16'd33606;
    logic [vidAddrWidth+dataWidth-1:0] expVid [$];   // {offset, data}
    logic [vidAddrWidth+dataWidth-1:0] beat;
    int                          vidErrors = 0;
    int                          ioErrors = 0;
    int                          otherErrors = 0;
    int                          cycles = 0;

    always #4 clk = ~clk;

    cpuTop dut (
        .clk(clk), .rst(rst), .run(run), .progWe(progWe), .progAddr(progAddr),
        .progData(progData), .ioPins(ioPins), .halted(halted), .ioDir(ioDir),
        .ioPort(ioPort), .vidWe(vidWe), .vidAddr(vidAddr), .vidData(vidData)
    );

    // ********************
    // Random source
    // ********************
    function automatic logic [15:0] lfsrNext(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
    endfunction

    function automatic int randBits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            v = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    // Returns {carry, zero, negative, result}
    function automatic logic [dataWidth+2:0] aluRef(logic [3:0] aluOp,
            logic [dataWidth-1:0] a, logic [dataWidth-1:0] b, logic cin);
        int                   sum;
        logic [dataWidth-1:0] res;
        sum = 0;
        case (aluOp)
            opAdd:   sum = int'(a) + int'(b);
            opAdc:   sum = int'(a) + int'(b) + int'(cin);
            opSub:   sum = int'(a) - int'(b) + 256;   // Bit 8 set when no borrow
            opAnd:   sum = int'(a & b);
            opOr:    sum = int'(a | b);
            opXor:   sum = int'(a ^ b);
            default: sum = 0;
        endcase
        res = 8'(sum);
        return {sum > 255, res == 0, res[dataWidth-1], res};
    endfunction

    // ********************
    // Program builder
    // ********************
    function automatic instrWord immI(logic [3:0] op, logic [3:0] rd, logic [7:0] imm);
        instrWord w;
        w.immForm.op  = op;
        w.immForm.rd  = rd;
        w.immForm.imm = imm;
        return w;
    endfunction

    function automatic instrWord regI(logic [3:0] op, logic [3:0] rd, logic [3:0] rs,
            logic [3:0] rt);
        instrWord w;
        w.regForm.op = op;
        w.regForm.rd = rd;
        w.regForm.rs = rs;
        w.regForm.rt = rt;
        return w;
    endfunction

    function automatic void emit(instrWord w);
        prog[progLen] = w;
        progLen++;
    endfunction

    // Pointer pair lives in r3:r2
    function automatic void pointTo(logic [memAddrWidth-1:0] addr);
        emit(immI(opLdi, 2, addr[7:0]));
        emit(immI(opLdi, 3, addr[15:8]));
    endfunction

    function automatic void storeToVid(logic [3:0] rd, logic [vidAddrWidth-1:0] offset);
        pointTo(vidBase + 16'(offset));
        emit(regI(opSt, rd, 2, 3));
    endfunction

    // ********************
    // Checks
    // ********************
    task automatic checkVid(logic [vidAddrWidth-1:0] gotAddr, logic [dataWidth-1:0] gotData,
            logic [vidAddrWidth-1:0] expAddr, logic [dataWidth-1:0] expData);
        if (gotAddr !== expAddr || gotData !== expData) begin
            vidErrors++;
            $display("Error at %0t ns: video write %h=%h, expected %h=%h",
                     $time, gotAddr, gotData, expAddr, expData);
        end
    endtask

    task automatic checkIo(string name, logic [dataWidth-1:0] got, logic [dataWidth-1:0] exp);
        if (got !== exp) begin
            ioErrors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        if (got !== exp) begin
            otherErrors++;
            $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    // Load under reset and run until halted
    task automatic runProgram();
        @(posedge clk);
        rst <= 1'b1;
        run <= 1'b0;
        for (int i = 0; i < progLen; i++) begin
            @(posedge clk);
            progWe   <= 1'b1;
            progAddr <= pcWidth'(i);
            progData <= prog[i];
        end
        @(posedge clk);
        progWe <= 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        run <= 1'b1;
        do @(negedge clk); while (!halted);
        @(posedge clk);
        run <= 1'b0;
        @(negedge clk);
        if (expVid.size() != 0) begin
            otherErrors++;
            $display("Program halted with %0d expected video writes missing", expVid.size());
            expVid.delete();
        end
    endtask

    // Every video beat is matched against the expected list
    always @(negedge clk) begin
        if (vidWe === 1'b1) begin
            if (expVid.size() == 0) begin
                otherErrors++;
                $display("Unexpected video write to offset %h at %0t ns", vidAddr, $time);
            end else begin
                beat = expVid.pop_front();
                checkVid(vidAddr, vidData, beat[vidAddrWidth+dataWidth-1:dataWidth],
                         beat[dataWidth-1:0]);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Run stopped after %0d cycles with programs still pending", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        logic [3:0]           aluOp;
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        logic [dataWidth+2:0] refOut;
        logic                 cin;
        logic [dataWidth-1:0] addr [4];
        logic [dataWidth-1:0] data [4];
        logic [dataWidth-1:0] dirVal;
        logic [dataWidth-1:0] portVal;
        rst      = 1'b1;
        run      = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        ioPins   = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkIo("ioDir", ioDir, '0);
        checkIo("ioPort", ioPort, '0);
        checkBit("vidWe", vidWe, 1'b0);
        checkBit("halted", halted, 1'b0);

        // Random ALU ops where Adc gets its carry from a preceding Add
        for (int k = 0; k < 40; k++) begin
            progLen = 0;
            cin     = 1'b0;
            aluOp   = 4'(randBits(3) % 6 + 1);
            if (aluOp == opAdc) begin
                a = 8'(randBits(8));
                b = 8'(randBits(8));
                emit(immI(opLdi, 4, a));
                emit(immI(opLdi, 5, b));
                emit(regI(opAdd, 6, 4, 5));
                refOut = aluRef(opAdd, a, b, 1'b0);
                cin    = refOut[dataWidth+2];
            end
            a = 8'(randBits(8));
            b = 8'(randBits(8));
            emit(immI(opLdi, 0, a));
            emit(immI(opLdi, 1, b));
            emit(regI(aluOp, 7, 0, 1));
            storeToVid(7, 12'(k));
            emit(immI(opHalt, 0, 0));
            refOut = aluRef(aluOp, a, b, cin);
            expVid.push_back({12'(k), refOut[dataWidth-1:0]});
            runProgram();
        end

        // Branch on zero skips the first store
        progLen = 0;
        a = 8'(randBits(8));
        emit(immI(opLdi, 0, a));
        emit(immI(opLdi, 1, a));
        emit(immI(opLdi, 5, 8'h11));
        pointTo(vidBase + 16'h010);
        emit(regI(opSub, 4, 0, 1));
        emit(immI(opBz, 0, 8'(progLen + 2)));
        emit(regI(opSt, 5, 2, 3));
        emit(immI(opLdi, 1, a ^ 8'h5A));
        emit(immI(opLdi, 5, 8'h22));
        pointTo(vidBase + 16'h011);
        emit(regI(opSub, 4, 0, 1));
        emit(immI(opBz, 0, 8'(progLen + 2)));
        emit(regI(opSt, 5, 2, 3));
        emit(immI(opHalt, 0, 0));
        expVid.push_back({12'h011, 8'h22});
        runProgram();

        // RAM round trip directly and through the 0x0800 alias
        progLen = 0;
        for (int i = 0; i < 4; i++) begin
            addr[i] = {6'(randBits(6)), 2'(i)};
            data[i] = 8'(randBits(8));
            emit(immI(opLdi, 0, data[i]));
            pointTo({8'h00, addr[i]});
            emit(regI(opSt, 0, 2, 3));
        end
        for (int i = 0; i < 4; i++) begin
            pointTo({8'h00, addr[i]});
            emit(regI(opLd, 1, 2, 3));
            storeToVid(1, 12'h100 + 12'(2 * i));
            pointTo({8'h08, addr[i]});
            emit(regI(opLd, 1, 2, 3));
            storeToVid(1, 12'h101 + 12'(2 * i));
            expVid.push_back({12'h100 + 12'(2 * i), data[i]});
            expVid.push_back({12'h101 + 12'(2 * i), data[i]});
        end
        emit(immI(opHalt, 0, 0));
        runProgram();

        // I/O registers and pins
        progLen = 0;
        dirVal  = 8'(randBits(8));
        portVal = 8'(randBits(8));
        emit(immI(opLdi, 0, dirVal));
        pointTo(ioDirAddr);
        emit(regI(opSt, 0, 2, 3));
        emit(immI(opLdi, 0, portVal));
        pointTo(ioPortAddr);
        emit(regI(opSt, 0, 2, 3));
        pointTo(ioPinsAddr);
        emit(regI(opLd, 1, 2, 3));
        storeToVid(1, 12'h030);
        emit(immI(opHalt, 0, 0));
        @(posedge clk);
        ioPins <= 8'(randBits(8));
        @(negedge clk);
        expVid.push_back({12'h030, ioPins});
        runProgram();
        checkIo("ioDir", ioDir, dirVal);
        checkIo("ioPort", ioPort, portVal);

        // Pair increment 0x20FF to 0x2100 and then an unmapped store
        progLen = 0;
        a = 8'(randBits(8));
        emit(immI(opLdi, 6, 8'hFF));
        emit(immI(opLdi, 7, 8'h20));
        emit(immI(opLdi, 1, a));
        emit(regI(opIncp, 0, 6, 0));
        emit(regI(opSt, 1, 6, 7));
        pointTo(16'h3000);
        emit(regI(opSt, 1, 2, 3));
        emit(immI(opHalt, 0, 0));
        expVid.push_back({12'h100, a});
        runProgram();

        repeat (4) @(posedge clk);
        $display("Errors: %0d video, %0d I/O, %0d assertion, %0d other",
                 vidErrors, ioErrors, dut.checks.failCount, otherErrors);
        if (vidErrors + ioErrors + dut.checks.failCount + otherErrors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* list.f */
logic/cpuPkg.sv
logic/fetchStage.sv
logic/regFile.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/cpuTop.sv
test/cpuTop_assertions.sv
test/cpuTb.sv
